// ==== all.f ====
+incdir+src
src/pmux_isa_pkg.sv
src/pmux_pipe_pkg.sv
src/stage_reg.sv
src/slot_extract.sv
src/flow_select.sv
src/flow_target.sv
src/pipeline_mux_top.sv
sim/pipeline_mux_asserts.sv
sim/pipeline_mux_tb.sv

// ==== sim/pipeline_mux_asserts.sv ====
// ==========================================================
// Handshake and flow-flag assertions for the multiplexer
// Bound to the top level, failures are tallied for the testbench
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module pipeline_mux_asserts (
	input wire                     clk,
	input wire                     rst_i,
	input wire                     in_ready_i,
	input wire                     out_valid_i,
	input wire                     out_ready_i,
	input pmux_pipe_pkg::mux_out_t out_data_i
);

	// Number of assertion failures so far, read by the testbench at the end
	int unsigned fail_count = 0;

	// A stalled output word has to stay offered and unchanged
	hold_on_stall: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
	else begin
		fail_count++;
		$error("output word dropped or changed while the sink stalled");
	end

	// A return never jumps or links in the same group
	ret_exclusive: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_i |-> !(out_data_i.flow.do_ret &&
			(out_data_i.flow.do_jump || out_data_i.flow.do_call)))
	else begin
		fail_count++;
		$error("do_ret raised together with do_jump or do_call");
	end

	// Both stages come out of reset empty, so the input side is open
	idle_after_reset: assert property (@(posedge clk)
		rst_i |=> !out_valid_i && in_ready_i)
	else begin
		fail_count++;
		$error("pipeline not empty in the cycle after reset");
	end

endmodule

bind pipeline_mux_top pipeline_mux_asserts pipeline_mux_asserts_inst (
	.clk         (clk),
	.rst_i       (rst_i),
	.in_ready_i  (in_ready_o),
	.out_valid_i (out_valid_o),
	.out_ready_i (out_ready_i),
	.out_data_i  (out_data_o)
);

`default_nettype wire

// ==== sim/pipeline_mux_tb.sv ====
// ==========================================================
// Testbench for the instruction-group multiplexer
// Clock, reset, directed and random bundles, reference model,
// output monitor and the closing report
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "pmux_macros.svh"

module pipeline_mux_tb;

	// Cycles a single wait may take before the run is abandoned
	localparam int WAIT_LIMIT = 500;

	logic                         clk;
	logic                         rst_i;
	logic                         in_valid_i;
	logic                         in_ready_o;
	pmux_pipe_pkg::fetch_bundle_t in_bundle_i;
	logic                         out_valid_o;
	logic                         out_ready_i;
	pmux_pipe_pkg::mux_out_t      out_data_o;

	// Expected words and their accept cycles, oldest first
	pmux_pipe_pkg::mux_out_t      exp_q[$];
	int                           acc_q[$];
	int                           cycle_cnt;
	int                           error_count;
	int                           err_mark;
	int                           check_count;
	int                           test_count;
	int                           seed;
	bit                           timed_out;
	bit                           check_latency;
	bit                           toggle_ready;

	pipeline_mux_top pipeline_mux_top_inst (
		.clk         (clk),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_bundle_i (in_bundle_i),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_data_o  (out_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// ==========================================================
	// Reference model
	// ==========================================================

	// Slot k reads word (pc[4:2] + k) and is dropped past the line end,
	// on irq or stomp, or when it lies below a branch-miss PC
	function automatic pmux_pipe_pkg::mux_out_t model_out(input pmux_pipe_pkg::fetch_bundle_t b);
		pmux_pipe_pkg::mux_out_t m;
		pmux_isa_pkg::instr_t    ins;
		logic [31:0]             spc;
		logic [31:0]             offs;
		int                      word;
		bit                      found;
		m = '0;
		found = 1'b0;
		m.flow.target = `PMUX_RESET_PC;
		m.flow.ret_pc = `PMUX_RESET_PC;
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			word = int'(b.pc[4:2]) + k;
			spc = b.pc + 32'(4 * k);
			m.grp.slot[k].pc = spc;
			m.grp.slot[k].v = !(word >= `PMUX_LINE_INS || b.irq || b.stomp ||
				(b.branchmiss && b.miss_pc > spc));
			if (m.grp.slot[k].v) begin
				ins = b.line[word * 32 +: 32];
				m.grp.slot[k].ins = ins;
				// Word displacement turned into a byte offset with its sign
				offs = {{5{ins.disp[24]}}, ins.disp, 2'b00};
				if (!found) begin
					found = 1'b1;
					case (ins.opcode)
						pmux_isa_pkg::OP_BRA: begin
							m.flow.do_jump = 1'b1;
							m.flow.target = spc + offs;
						end
						pmux_isa_pkg::OP_BSR: begin
							m.flow.do_jump = 1'b1;
							m.flow.do_call = 1'b1;
							m.flow.target = spc + offs;
							m.flow.ret_pc = spc + 32'd4;
						end
						pmux_isa_pkg::OP_JSRR: begin
							m.flow.do_call = 1'b1;
							m.flow.ret_pc = spc + 32'd4;
						end
						pmux_isa_pkg::OP_RET: begin
							m.flow.do_ret = 1'b1;
						end
						default: begin
							found = 1'b0;
						end
					endcase
				end
			end
		end
		return m;
	endfunction

	// ==========================================================
	// Stimulus helpers
	// ==========================================================

	function automatic logic [31:0] ins_word(input pmux_isa_pkg::opcode_e op,
		input logic [24:0] disp);
		return {disp, op};
	endfunction

	// Flow opcodes with the given chance in percent, plain ones otherwise
	function automatic logic [31:0] rand_ins(input int flow_pct);
		logic [24:0]           disp;
		int                    pick;
		pmux_isa_pkg::opcode_e op;
		disp = 25'($random(seed));
		pick = int'($unsigned($random(seed)) % 100);
		if (pick < flow_pct) begin
			case (pick % 4)
				0: op = pmux_isa_pkg::OP_BRA;
				1: op = pmux_isa_pkg::OP_BSR;
				2: op = pmux_isa_pkg::OP_JSRR;
				default: op = pmux_isa_pkg::OP_RET;
			endcase
		end else begin
			case (pick % 6)
				0: op = pmux_isa_pkg::OP_ADD;
				1: op = pmux_isa_pkg::OP_SUB;
				2: op = pmux_isa_pkg::OP_AND;
				3: op = pmux_isa_pkg::OP_OR;
				4: op = pmux_isa_pkg::OP_LOAD;
				default: op = pmux_isa_pkg::OP_STORE;
			endcase
		end
		return ins_word(op, disp);
	endfunction

	function automatic logic [`PMUX_LINE_W-1:0] rand_line(input int flow_pct);
		logic [`PMUX_LINE_W-1:0] line;
		for (int w = 0; w < `PMUX_LINE_INS; w++) begin
			line[w * 32 +: 32] = rand_ins(flow_pct);
		end
		return line;
	endfunction

	function automatic pmux_pipe_pkg::fetch_bundle_t make_bundle(input logic [31:0] pc,
		input logic [`PMUX_LINE_W-1:0] line);
		pmux_pipe_pkg::fetch_bundle_t b;
		b = '0;
		b.pc = pc;
		b.line = line;
		return b;
	endfunction

	// One clock edge; during back-pressure the sink ready is redrawn here
	task automatic step_cycle();
		int rnd;
		@(posedge clk);
		if (toggle_ready) begin
			rnd = $random(seed);
			out_ready_i <= rnd[0];
		end
	endtask

	// Offer a bundle until it is taken, then log what must come out
	task automatic send_bundle(input pmux_pipe_pkg::fetch_bundle_t b);
		int waited;
		bit taken;
		waited = 0;
		taken = 1'b0;
		in_valid_i <= 1'b1;
		in_bundle_i <= b;
		while (!taken && !timed_out) begin
			step_cycle();
			waited++;
			if (in_ready_o) begin
				taken = 1'b1;
				exp_q.push_back(model_out(b));
				acc_q.push_back(cycle_cnt);
			end else if (waited > WAIT_LIMIT) begin
				timed_out = 1'b1;
				$display("Timeout: a bundle was never accepted by the DUT");
			end
		end
	endtask

	// Stop offering and wait until every logged word has come out
	task automatic drain();
		int waited;
		waited = 0;
		in_valid_i <= 1'b0;
		while (exp_q.size() != 0 && !timed_out) begin
			step_cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				timed_out = 1'b1;
				$display("Timeout: %0d expected output words never appeared", exp_q.size());
			end
		end
	endtask

	// ==========================================================
	// Checking
	// ==========================================================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		check_count++;
		assert (got === want) else begin
			error_count++;
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
		end
	endtask

	task automatic compare_out(input pmux_pipe_pkg::mux_out_t want);
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			check_value($sformatf("slot%0d.v", k), 32'(out_data_o.grp.slot[k].v),
				32'(want.grp.slot[k].v));
			check_value($sformatf("slot%0d.ins", k), out_data_o.grp.slot[k].ins,
				want.grp.slot[k].ins);
			check_value($sformatf("slot%0d.pc", k), out_data_o.grp.slot[k].pc,
				want.grp.slot[k].pc);
		end
		check_value("do_jump", 32'(out_data_o.flow.do_jump), 32'(want.flow.do_jump));
		check_value("do_call", 32'(out_data_o.flow.do_call), 32'(want.flow.do_call));
		check_value("do_ret", 32'(out_data_o.flow.do_ret), 32'(want.flow.do_ret));
		check_value("target", out_data_o.flow.target, want.flow.target);
		check_value("ret_pc", out_data_o.flow.ret_pc, want.flow.ret_pc);
	endtask

	// Every output transfer is matched against the oldest logged bundle
	always @(posedge clk) begin
		pmux_pipe_pkg::mux_out_t want;
		int acc;
		if (!rst_i && out_valid_o && out_ready_i) begin
			if (exp_q.size() == 0) begin
				error_count++;
				$display("An output word appeared with no bundle outstanding");
			end else begin
				want = exp_q.pop_front();
				acc = acc_q.pop_front();
				compare_out(want);
				if (check_latency) begin
					check_value("latency", cycle_cnt - acc, 32'd2);
				end
			end
		end
	end

	task automatic end_test(input string name);
		test_count++;
		if (timed_out) begin
			$display("Test %0d %s: stopped by a timeout", test_count, name);
		end else begin
			$display("Test %0d %s: done, %0d errors", test_count, name, error_count - err_mark);
		end
		err_mark = error_count;
	endtask

	// ==========================================================
	// Tests
	// ==========================================================

	// Plain lines at each word offset in [lo, hi], three per offset
	task automatic run_offsets(input int lo, input int hi);
		logic [31:0] base;
		check_latency = 1'b1;
		for (int off = lo; off <= hi; off++) begin
			for (int n = 0; n < 3; n++) begin
				base = $random(seed);
				send_bundle(make_bundle({base[31:5], 5'(off * 4)}, rand_line(0)));
			end
		end
		drain();
		check_latency = 1'b0;
	endtask

	task automatic run_invalidation();
		pmux_pipe_pkg::fetch_bundle_t b;
		logic [31:0] base;
		base = $random(seed);
		b = make_bundle({base[31:5], 5'd0}, rand_line(60));
		b.irq = 1'b1;
		send_bundle(b);
		b = make_bundle({base[31:5], 5'd0}, rand_line(60));
		b.stomp = 1'b1;
		send_bundle(b);
		// Miss PC halfway between slot j and slot j+1
		for (int j = 0; j < 3; j++) begin
			b = make_bundle({base[31:5], 5'd0}, rand_line(60));
			b.branchmiss = 1'b1;
			b.miss_pc = b.pc + 32'(4 * j + 2);
			send_bundle(b);
		end
		drain();
	endtask

	task automatic run_flow(input int count);
		pmux_pipe_pkg::fetch_bundle_t b;
		logic [`PMUX_LINE_W-1:0] line;
		logic [31:0] base;
		// The call in slot 0 is on the wrong path, the backward jump wins
		base = $random(seed);
		line = rand_line(0);
		line[31:0] = ins_word(pmux_isa_pkg::OP_BSR, 25'd5);
		line[63:32] = ins_word(pmux_isa_pkg::OP_BRA, -25'sd3);
		b = make_bundle({base[31:5], 5'd0}, line);
		b.branchmiss = 1'b1;
		b.miss_pc = b.pc + 32'd2;
		send_bundle(b);
		for (int n = 0; n < count; n++) begin
			base = $random(seed);
			b = make_bundle({base[31:2], 2'b00}, rand_line(40));
			if ($unsigned($random(seed)) % 4 == 0) begin
				b.branchmiss = 1'b1;
				b.miss_pc = b.pc + 32'($unsigned($random(seed)) % 16);
			end
			send_bundle(b);
		end
		drain();
	endtask

	task automatic run_backpressure();
		logic [31:0] base;
		toggle_ready = 1'b1;
		for (int n = 0; n < 40; n++) begin
			// Occasional empty cycle on the input side
			if ($unsigned($random(seed)) % 4 == 0) begin
				in_valid_i <= 1'b0;
				step_cycle();
			end
			base = $random(seed);
			send_bundle(make_bundle({base[31:2], 2'b00}, rand_line(40)));
		end
		drain();
		toggle_ready = 1'b0;
		out_ready_i <= 1'b1;
	endtask

	initial begin
		seed = 28198;
		cycle_cnt = 0;
		error_count = 0;
		err_mark = 0;
		check_count = 0;
		test_count = 0;
		timed_out = 1'b0;
		check_latency = 1'b0;
		toggle_ready = 1'b0;
		rst_i = 1'b1;
		in_valid_i = 1'b0;
		in_bundle_i = '0;
		out_ready_i = 1'b1;
		repeat (16) @(posedge clk);
		rst_i <= 1'b0;
		@(posedge clk);

		check_value("out_valid_o", 32'(out_valid_o), 32'd0);
		check_value("in_ready_o", 32'(in_ready_o), 32'd1);
		end_test("reset state");
		run_offsets(0, 4);
		end_test("alignment");
		run_offsets(6, 7);
		end_test("end of line");
		run_invalidation();
		end_test("invalidation");
		run_flow(40);
		end_test("flow selection");
		run_backpressure();
		end_test("back-pressure");
		repeat (4) @(posedge clk);

		$display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d", test_count,
			check_count, error_count, pipeline_mux_top_inst.pipeline_mux_asserts_inst.fail_count);
		if (error_count == 0 && !timed_out &&
			pipeline_mux_top_inst.pipeline_mux_asserts_inst.fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/flow_select.sv ====
// ==========================================================
// Flow selection (execute)
// Classifies the slots of a group and picks the oldest valid
// slot that changes control flow
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "pmux_macros.svh"

module flow_select (
	input  pmux_pipe_pkg::slot_group_t group_i,
	output logic [1:0]                 idx_o,
	output pmux_isa_pkg::flow_e        kind_o
);

	// Map one slot to its flow kind
	// Invalid slots never request anything
	function automatic pmux_isa_pkg::flow_e slot_kind(pmux_pipe_pkg::slot_t s);
		pmux_isa_pkg::flow_e kind;
		kind = pmux_isa_pkg::FLOW_NONE;
		if (s.v) begin
			case (s.ins.opcode)
				pmux_isa_pkg::OP_BRA:  kind = pmux_isa_pkg::FLOW_JUMP;
				pmux_isa_pkg::OP_BSR:  kind = pmux_isa_pkg::FLOW_CALL;
				pmux_isa_pkg::OP_JSRR: kind = pmux_isa_pkg::FLOW_RCALL;
				pmux_isa_pkg::OP_RET:  kind = pmux_isa_pkg::FLOW_RET;
				default:               kind = pmux_isa_pkg::FLOW_NONE;
			endcase
		end
		return kind;
	endfunction

	// Priority search from slot 0 upward, the first hit wins
	// Everything after it is on a path that will not be taken
	always_comb begin
		logic                found;
		pmux_isa_pkg::flow_e kind;
		found  = 1'b0;
		idx_o  = 2'd0;
		kind_o = pmux_isa_pkg::FLOW_NONE;
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			kind = slot_kind(group_i.slot[k]);
			if (!found && kind != pmux_isa_pkg::FLOW_NONE) begin
				found  = 1'b1;
				idx_o  = 2'(k);
				kind_o = kind;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/flow_target.sv ====
// ==========================================================
// Flow result (result)
// Builds the jump target, the return PC and the flow flags
// for the slot picked by flow selection
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "pmux_macros.svh"

module flow_target (
	input  pmux_pipe_pkg::slot_group_t  group_i,
	input  wire [1:0]                   idx_i,
	input  pmux_isa_pkg::flow_e         kind_i,
	output pmux_pipe_pkg::flow_result_t result_o
);

	pmux_pipe_pkg::slot_t  sel;
	logic [`PMUX_PC_W-1:0] disp_ext;

	// The winning slot, slot 0 when no flow was found
	assign sel = group_i.slot[idx_i];

	// Word displacement widened with its sign to a PC offset
	assign disp_ext = `PMUX_PC_W'($signed(sel.ins.disp));

	always_comb begin
		// A call is a jump that also saves the link
		result_o.do_jump = (kind_i == pmux_isa_pkg::FLOW_JUMP) ||
			(kind_i == pmux_isa_pkg::FLOW_CALL);
		// Register calls link too but their target is resolved later
		result_o.do_call = (kind_i == pmux_isa_pkg::FLOW_CALL) ||
			(kind_i == pmux_isa_pkg::FLOW_RCALL);
		result_o.do_ret  = kind_i == pmux_isa_pkg::FLOW_RET;

		// Target is relative to the PC of the flow instruction itself
		if (result_o.do_jump) begin
			result_o.target = sel.pc + (disp_ext << 2);
		end else begin
			result_o.target = `PMUX_RESET_PC;
		end

		// Return lands on the word after the call
		if (result_o.do_call) begin
			result_o.ret_pc = sel.pc + `PMUX_PC_W'(4);
		end else begin
			result_o.ret_pc = `PMUX_RESET_PC;
		end
	end

endmodule

`default_nettype wire

// ==== src/pipeline_mux_top.sv ====
// ==========================================================
// Instruction-group multiplexer top level
// Slot extraction, first pipeline stage, flow search, flow
// result and second pipeline stage in a row
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module pipeline_mux_top (
	input  wire                           clk,
	input  wire                           rst_i,
	// Fetch side
	input  wire                           in_valid_i,
	output logic                          in_ready_o,
	input  pmux_pipe_pkg::fetch_bundle_t  in_bundle_i,
	// Toward rename and the branch unit
	output logic                          out_valid_o,
	input  wire                           out_ready_i,
	output pmux_pipe_pkg::mux_out_t       out_data_o
);

	// ==========================================================
	// Stage 1: aligned slots
	// ==========================================================

	pmux_pipe_pkg::slot_group_t   grp_d;
	pmux_pipe_pkg::slot_group_t   s1_grp;
	logic                         s1_valid;
	logic                         s1_ready;

	slot_extract slot_extract_inst (
		.bundle_i (in_bundle_i),
		.group_o  (grp_d)
	);

	stage_reg #(
		.payload_t (pmux_pipe_pkg::slot_group_t)
	) stage1_inst (
		.clk     (clk),
		.rst_i   (rst_i),
		.valid_i (in_valid_i),
		.ready_o (in_ready_o),
		.data_i  (grp_d),
		.valid_o (s1_valid),
		.ready_i (s1_ready),
		.data_o  (s1_grp)
	);

	// ==========================================================
	// Stage 2: flow decision travels with its group
	// ==========================================================

	logic [1:0]                   flow_idx;
	pmux_isa_pkg::flow_e          flow_kind;
	pmux_pipe_pkg::flow_result_t  s1_flow;
	pmux_pipe_pkg::mux_out_t      s2_d;

	flow_select flow_select_inst (
		.group_i (s1_grp),
		.idx_o   (flow_idx),
		.kind_o  (flow_kind)
	);

	flow_target flow_target_inst (
		.group_i  (s1_grp),
		.idx_i    (flow_idx),
		.kind_i   (flow_kind),
		.result_o (s1_flow)
	);

	assign s2_d = '{grp: s1_grp, flow: s1_flow};

	stage_reg #(
		.payload_t (pmux_pipe_pkg::mux_out_t)
	) stage2_inst (
		.clk     (clk),
		.rst_i   (rst_i),
		.valid_i (s1_valid),
		.ready_o (s1_ready),
		.data_i  (s2_d),
		.valid_o (out_valid_o),
		.ready_i (out_ready_i),
		.data_o  (out_data_o)
	);

endmodule

`default_nettype wire

// ==== src/pmux_isa_pkg.sv ====
// ==========================================================
// Instruction encoding seen by the front end
// Opcode enumeration, instruction word layout and the kinds
// of control-flow change a slot can request
// ==========================================================

`default_nettype none

`include "pmux_macros.svh"

package pmux_isa_pkg;

	// ==========================================================
	// Opcodes
	// ==========================================================

	// Only the four flow opcodes matter to the multiplexer
	// Any value not listed is executed as a plain instruction
	typedef enum logic [6:0] {
		OP_NOP   = 7'h00,
		OP_ADD   = 7'h01,
		OP_SUB   = 7'h02,
		OP_AND   = 7'h03,
		OP_OR    = 7'h04,
		OP_LOAD  = 7'h10,
		OP_STORE = 7'h11,
		// PC-relative jump
		OP_BRA   = 7'h40,
		// PC-relative call, links the next PC
		OP_BSR   = 7'h41,
		// Call through a register, target comes later in the pipe
		OP_JSRR  = 7'h42,
		// Return through the link
		OP_RET   = 7'h43
	} opcode_e;

	// ==========================================================
	// Instruction word
	// ==========================================================

	// The displacement counts words and is sign extended before use
	typedef struct packed {
		logic [`PMUX_INS_W-8:0] disp;
		opcode_e                opcode;
	} instr_t;

	// Kind of control-flow change, FLOW_NONE when the slot falls through
	typedef enum logic [2:0] {
		FLOW_NONE  = 3'd0,
		FLOW_JUMP  = 3'd1,
		FLOW_CALL  = 3'd2,
		FLOW_RCALL = 3'd3,
		FLOW_RET   = 3'd4
	} flow_e;

endpackage

`default_nettype wire

// ==== src/pmux_macros.svh ====
// ==========================================================
// Global sizes of the instruction-group multiplexer
// Instruction, PC and cache line widths, slot count per group
// and the PC reported when no flow target applies
// ==========================================================

`ifndef PMUX_MACROS_SVH
`define PMUX_MACROS_SVH

// One instruction word is 32 bits wide
`define PMUX_INS_W 32

// Program counter width
`define PMUX_PC_W 32

// A fetched line holds eight instruction words
`define PMUX_LINE_INS 8
`define PMUX_LINE_W 256

// Four slots are handed on per group
`define PMUX_SLOTS 4

// Target and return PC when the group carries no flow change
`define PMUX_RESET_PC 32'hFFFC0000

`endif

// ==== src/pmux_pipe_pkg.sv ====
// ==========================================================
// Bundles that travel between the pipeline stages
// Fetch bundle, slot, slot group, flow result and the
// combined output word
// ==========================================================

`default_nettype none

`include "pmux_macros.svh"

package pmux_pipe_pkg;

	// Everything the fetch stage hands over for one cache line
	typedef struct packed {
		// Word 0 sits in the low 32 bits
		logic [`PMUX_LINE_W-1:0] line;
		logic [`PMUX_PC_W-1:0]   pc;
		// Slots below the miss PC are killed
		logic                    branchmiss;
		logic [`PMUX_PC_W-1:0]   miss_pc;
		logic                    irq;
		logic                    stomp;
	} fetch_bundle_t;

	// One extracted instruction with its own PC
	typedef struct packed {
		pmux_isa_pkg::instr_t  ins;
		logic [`PMUX_PC_W-1:0] pc;
		logic                  v;
	} slot_t;

	// Slot 0 is the oldest instruction of the group
	typedef struct packed {
		slot_t [`PMUX_SLOTS-1:0] slot;
	} slot_group_t;

	// Outcome of the flow search over one group
	typedef struct packed {
		logic                  do_jump;
		logic                  do_call;
		logic                  do_ret;
		logic [`PMUX_PC_W-1:0] target;
		logic [`PMUX_PC_W-1:0] ret_pc;
	} flow_result_t;

	// Word leaving the second stage
	typedef struct packed {
		slot_group_t  grp;
		flow_result_t flow;
	} mux_out_t;

endpackage

`default_nettype wire

// ==== src/slot_extract.sv ====
// ==========================================================
// Slot extraction (decode)
// Aligns the fetched line to the fetch PC, cuts out four
// instruction slots and marks the ones that must not issue
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "pmux_macros.svh"

module slot_extract (
	input  pmux_pipe_pkg::fetch_bundle_t bundle_i,
	output pmux_pipe_pkg::slot_group_t   group_o
);

	// Word position of the fetch PC within the line
	logic [2:0] base_idx;
	assign base_idx = bundle_i.pc[4:2];

	// An interrupt or a stomp throws the whole group away
	logic kill_all;
	assign kill_all = bundle_i.irq || bundle_i.stomp;

	always_comb begin
		logic [3:0]            widx;
		logic [`PMUX_PC_W-1:0] spc;
		logic                  off_end;
		logic                  missed;
		pmux_pipe_pkg::slot_t  s;
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			// One extra bit so running past word 7 is visible
			widx = {1'b0, base_idx} + 4'(k);
			spc  = bundle_i.pc + (`PMUX_PC_W'(k) << 2);

			// Slots past the end of the line have nothing to take
			off_end = widx > 4'(`PMUX_LINE_INS - 1);

			// Instructions before the branch-miss PC belong to the wrong path
			missed = bundle_i.branchmiss && (bundle_i.miss_pc > spc);

			s.pc  = spc;
			s.v   = !(off_end || kill_all || missed);
			s.ins = bundle_i.line[widx[2:0]*`PMUX_INS_W +: `PMUX_INS_W];

			// A dead slot is turned into a NOP so later stages see no opcode
			if (!s.v) begin
				s.ins.disp   = '0;
				s.ins.opcode = pmux_isa_pkg::OP_NOP;
			end

			group_o.slot[k] = s;
		end
	end

endmodule

`default_nettype wire

// ==== src/stage_reg.sv ====
// ==========================================================
// Single-entry valid/ready pipeline register
// The payload type is chosen per instance
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic
) (
	input  wire      clk,
	input  wire      rst_i,
	// Upstream side
	input  wire      valid_i,
	output logic     ready_o,
	input  payload_t data_i,
	// Downstream side
	output logic     valid_o,
	input  wire      ready_i,
	output payload_t data_o
);

	logic     full_q;
	payload_t data_q;
	logic     load;

	// Room is available when empty or when the held entry leaves now
	// This makes ready ripple back through chained stages in one cycle
	assign ready_o = !full_q || ready_i;
	assign load    = valid_i && ready_o;

	// Occupancy follows the upstream valid whenever the slot can change
	// A stalled entry keeps full_q set
	always_ff @(posedge clk) begin
		if (rst_i) begin
			full_q <= 1'b0;
		end else if (ready_o) begin
			full_q <= valid_i;
		end
	end

	// Payload only moves on an accepted transfer
	always_ff @(posedge clk) begin
		if (load) begin
			data_q <= data_i;
		end
	end

	assign valid_o = full_q;
	assign data_o  = data_q;

endmodule

`default_nettype wire
